/* source/dma_defs.svh */
// Bus widths, register map offsets and size limits of the DMA core, included by every RTL file
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

////////////////////////////////////////////////////////////
// Stream widths
////////////////////////////////////////////////////////////
`define DMA_DATA_WIDTH       256
`define DMA_DW_KEEP_WIDTH    8                // One bit per dword
`define DMA_BYTE_KEEP_WIDTH  32               // One bit per byte

////////////////////////////////////////////////////////////
// Register port
////////////////////////////////////////////////////////////
`define DMA_REG_WIDTH        64
`define DMA_ADDR_WIDTH       16
`define DMA_ENGINE_BASE      16'h0200
`define DMA_GLOBAL_OFFSET    16'h2200         // Engine base plus one engine stride

////////////////////////////////////////////////////////////
// Request limits
////////////////////////////////////////////////////////////
`define DMA_WINDOW_SIZE      4                // Requests in flight
`define DMA_TAG_WIDTH        2
`define DMA_LOG2_MAX_PAYLOAD 8                // 256 byte payload
`define DMA_LOG2_MAX_READ_REQUEST 12          // 4 KB read request
`define DMA_LEN_WIDTH        11               // Request length in dwords

`endif

/* source/dma_pkg.sv */
// Shared state, register offset and vector types, imported by the DMA core modules and testbench
`include "dma_defs.svh"

package dma_pkg;

	////////////////////////////////////////////////////////////
	// Register map
	////////////////////////////////////////////////////////////
	typedef enum logic [`DMA_ADDR_WIDTH-1:0] {
		ENG_CTRL    = `DMA_ENGINE_BASE,
		ENG_ADDR    = `DMA_ENGINE_BASE + 16'h0008,
		ENG_SIZE    = `DMA_ENGINE_BASE + 16'h0010,
		GLOBAL_CTRL = `DMA_GLOBAL_OFFSET
	} reg_offset_e;

	////////////////////////////////////////////////////////////
	// State machines
	////////////////////////////////////////////////////////////
	typedef enum logic [1:0] {
		ENG_IDLE,
		ENG_RUN,   // Descriptor in progress
		ENG_DONE
	} engine_state_e;

	typedef enum logic [1:0] {
		RQ_IDLE,
		RQ_CALC,   // Length of next request
		RQ_ISSUE,  // rq_valid held until accepted
		RQ_WAIT    // Window check
	} rq_state_e;

	// Vector types
	typedef logic [`DMA_REG_WIDTH-1:0]       reg_data_t;
	typedef logic [63:0]                     host_addr_t;
	typedef logic [`DMA_LEN_WIDTH-1:0]       dw_len_t;
	typedef logic [`DMA_TAG_WIDTH-1:0]       tag_t;
	typedef logic [`DMA_DATA_WIDTH-1:0]      data_beat_t;
	typedef logic [`DMA_DW_KEEP_WIDTH-1:0]   dw_keep_t;
	typedef logic [`DMA_BYTE_KEEP_WIDTH-1:0] byte_keep_t;

endpackage

/* source/dma_registers.sv */
// Host register block of the DMA core: descriptor, status, global control, soft reset and irq
`timescale 1ns/100ps
`include "dma_defs.svh"

module dma_registers (
	input  logic                             CLK,
	input  logic                             dma_reset_n,
	input  logic                             reg_en,
	input  dma_pkg::reg_offset_e             reg_addr,
	input  logic [`DMA_REG_WIDTH/8-1:0]      reg_we,
	input  dma_pkg::reg_data_t               reg_din,
	output dma_pkg::reg_data_t               reg_dout,
	output logic                             reg_ack,
	input  logic                             running,
	input  logic                             done_pulse,
	output logic                             start,
	output dma_pkg::host_addr_t              desc_addr,
	output dma_pkg::reg_data_t               desc_size,
	output logic                             engine_reset_n,
	output logic                             irq
);
	import dma_pkg::*;

	localparam logic [2:0] MAX_PAYLOAD_CODE = 3'(`DMA_LOG2_MAX_PAYLOAD - 7);
	localparam logic [2:0] MAX_RDREQ_CODE   = 3'(`DMA_LOG2_MAX_READ_REQUEST - 7);

	reg_data_t read_word;
	logic      addr_mapped;
	logic      reg_write;
	logic      ctrl_write;
	logic      global_write;
	logic      soft_reset;
	logic      irq_en;
	logic      done_r;
	logic      irq_pending;

	// Byte-enable merge of a register write
	function automatic reg_data_t merge_bytes(
		input reg_data_t                    old_val,
		input reg_data_t                    new_val,
		input logic [`DMA_REG_WIDTH/8-1:0]  be
	);
		reg_data_t merged;
		merged = old_val;
		for (int i = 0; i < `DMA_REG_WIDTH/8; i++) begin
			if (be[i]) begin
				merged[8*i +: 8] = new_val[8*i +: 8];
			end
		end
		return merged;
	endfunction

	assign reg_write    = reg_en && (reg_we != '0);
	assign ctrl_write   = reg_write && (reg_addr == ENG_CTRL) && reg_we[0];
	assign global_write = reg_write && (reg_addr == GLOBAL_CTRL) && reg_we[0];

	////////////////////////////////////////////////////////////
	// Read side
	////////////////////////////////////////////////////////////
	always_comb begin
		read_word   = '0;
		addr_mapped = 1'b1;
		case (reg_addr)
			ENG_CTRL:    read_word = {56'd0, irq_pending, 5'd0, done_r, running};
			ENG_ADDR:    read_word = desc_addr;
			ENG_SIZE:    read_word = desc_size;
			GLOBAL_CTRL: read_word = {56'd0, 1'b0, irq_en, MAX_RDREQ_CODE, MAX_PAYLOAD_CODE};
			default:     addr_mapped = 1'b0;      // Unmapped offsets never ack
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!dma_reset_n) begin
			reg_ack <= 1'b0;
		end else begin
			reg_ack <= reg_en && addr_mapped;
		end
	end

	always_ff @(posedge CLK) begin
		if (reg_en) begin
			reg_dout <= read_word;
		end
	end

	////////////////////////////////////////////////////////////
	// Descriptor
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (reg_write && (reg_addr == ENG_ADDR)) begin
			desc_addr <= merge_bytes(desc_addr, reg_din, reg_we);
		end
		if (reg_write && (reg_addr == ENG_SIZE)) begin
			desc_size <= merge_bytes(desc_size, reg_din, reg_we);
		end
	end

	////////////////////////////////////////////////////////////
	// Control and status
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (!dma_reset_n) begin
			start       <= 1'b0;
			soft_reset  <= 1'b0;
			irq_en      <= 1'b0;
			done_r      <= 1'b0;
			irq_pending <= 1'b0;
		end else begin
			start      <= ctrl_write && reg_din[0] && !running;   // Idle or done only
			soft_reset <= global_write && reg_din[7];             // Self-clearing
			if (global_write) begin
				irq_en <= reg_din[6];
			end
			if (done_pulse) begin
				done_r      <= 1'b1;
				irq_pending <= 1'b1;
			end else if ((ctrl_write && reg_din[7]) || soft_reset) begin
				done_r      <= 1'b0;
				irq_pending <= 1'b0;
			end else if (start) begin
				done_r <= 1'b0;                                   // New descriptor under way
			end
		end
	end

	// Engine sees one cycle of reset per soft reset write
	assign engine_reset_n = dma_reset_n & ~soft_reset;
	assign irq            = irq_pending & irq_en;

endmodule

/* source/dma_read_requester.sv */
// Read request generator of the DMA core: splits a descriptor into tagged requests under the window
`timescale 1ns/100ps
`include "dma_defs.svh"

module dma_read_requester (
	input  logic                    CLK,
	input  logic                    engine_reset_n,
	input  logic                    start,
	input  dma_pkg::host_addr_t     desc_addr,
	input  dma_pkg::reg_data_t      desc_size,
	input  logic                    rq_ready,
	input  logic                    request_retired,
	output logic                    rq_valid,
	output dma_pkg::host_addr_t     rq_addr,
	output dma_pkg::dw_len_t        rq_len,
	output dma_pkg::tag_t           rq_tag,
	output logic                    running,
	output logic                    all_issued,
	output logic [`DMA_TAG_WIDTH:0] outstanding,
	output logic                    done_pulse
);
	import dma_pkg::*;

	localparam logic [12:0] PAGE_BYTES   = 13'h1000;                              // 4 KB boundary
	localparam logic [12:0] MAX_RD_BYTES = 13'(1 << `DMA_LOG2_MAX_READ_REQUEST);

	rq_state_e     rq_state;
	engine_state_e eng_state;
	host_addr_t    cur_addr;
	reg_data_t     remaining;
	logic [12:0]   boundary_bytes;
	logic [12:0]   len_bytes;
	logic [12:0]   issued_bytes;
	logic          rq_accept;
	logic          last_request;

	////////////////////////////////////////////////////////////
	// Request length
	////////////////////////////////////////////////////////////
	always_comb begin
		boundary_bytes = PAGE_BYTES - {1'b0, cur_addr[11:0]};
		len_bytes      = (boundary_bytes < MAX_RD_BYTES) ? boundary_bytes : MAX_RD_BYTES;
		if (remaining < 64'(len_bytes)) begin
			len_bytes = remaining[12:0];
		end
	end

	assign issued_bytes = {rq_len, 2'b00};
	assign rq_accept    = rq_valid && rq_ready;
	assign last_request = (remaining == 64'(issued_bytes));

	////////////////////////////////////////////////////////////
	// Request FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (!engine_reset_n) begin
			rq_state   <= RQ_IDLE;
			rq_valid   <= 1'b0;
			rq_tag     <= '0;         // Tags run on across descriptors, as do expected tags
			all_issued <= 1'b0;
		end else begin
			case (rq_state)
				RQ_IDLE: if (start) begin
					cur_addr   <= desc_addr;
					remaining  <= desc_size;
					all_issued <= (desc_size == '0);
					rq_state   <= (desc_size == '0) ? RQ_IDLE : RQ_CALC;
				end
				RQ_CALC: begin
					rq_addr  <= cur_addr;
					rq_len   <= len_bytes[12:2];
					rq_state <= RQ_WAIT;
				end
				RQ_WAIT: if (outstanding < `DMA_WINDOW_SIZE) begin
					rq_valid <= 1'b1;
					rq_state <= RQ_ISSUE;
				end
				RQ_ISSUE: if (rq_ready) begin
					rq_valid  <= 1'b0;
					rq_tag    <= rq_tag + 1'b1;                // Modulo 4
					cur_addr  <= cur_addr + 64'(issued_bytes);
					remaining <= remaining - 64'(issued_bytes);
					if (last_request) begin
						all_issued <= 1'b1;
						rq_state   <= RQ_IDLE;
					end else begin
						rq_state <= RQ_CALC;
					end
				end
				default: rq_state <= RQ_IDLE;
			endcase
		end
	end

	// Requests in flight
	always_ff @(posedge CLK) begin
		if (!engine_reset_n) begin
			outstanding <= '0;
		end else begin
			case ({rq_accept, request_retired})
				2'b10:   outstanding <= outstanding + 1'b1;
				2'b01:   outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Engine tracking
	////////////////////////////////////////////////////////////
	// Ends on the cycle the final request retires
	assign done_pulse = (eng_state == ENG_RUN) && all_issued &&
		((outstanding == '0) || ((outstanding == 1) && request_retired));

	always_ff @(posedge CLK) begin
		if (!engine_reset_n) begin
			eng_state <= ENG_IDLE;
		end else begin
			case (eng_state)
				ENG_RUN: if (done_pulse) eng_state <= ENG_DONE;
				default: if (start)      eng_state <= ENG_RUN;   // From idle or done
			endcase
		end
	end

	assign running = (eng_state == ENG_RUN);

endmodule

/* source/dma_completion_stream.sv */
// Completion path of the DMA core: forwards completion beats to the S2C stream and retires requests
`timescale 1ns/100ps
`include "dma_defs.svh"

module dma_completion_stream (
	input  logic                    CLK,
	input  logic                    engine_reset_n,
	input  logic                    rc_valid,
	output logic                    rc_ready,
	input  dma_pkg::data_beat_t     rc_data,
	input  dma_pkg::dw_keep_t       rc_keep,
	input  logic                    rc_last,
	input  dma_pkg::tag_t           rc_tag,
	output logic                    s2c_valid,
	input  logic                    s2c_ready,
	output dma_pkg::data_beat_t     s2c_data,
	output dma_pkg::byte_keep_t     s2c_keep,
	output logic                    s2c_last,
	input  logic                    all_issued,
	input  logic [`DMA_TAG_WIDTH:0] outstanding,
	output logic                    request_retired
);
	import dma_pkg::*;

	tag_t       expected_tag;     // Tag of the oldest request in flight
	byte_keep_t keep_expanded;
	logic       beat_accept;
	logic       tag_match;
	logic       final_beat;

	////////////////////////////////////////////////////////////
	// Beat forwarding
	////////////////////////////////////////////////////////////
	// No buffering here, S2C back-pressure reaches rc directly
	assign rc_ready  = s2c_ready;
	assign s2c_valid = rc_valid;
	assign s2c_data  = rc_data;

	always_comb begin
		for (int i = 0; i < `DMA_DW_KEEP_WIDTH; i++) begin
			keep_expanded[4*i +: 4] = {4{rc_keep[i]}};
		end
	end

	// Last beat of the last request of the descriptor
	assign final_beat = rc_last && all_issued && (outstanding == 1);
	assign s2c_last   = final_beat;
	assign s2c_keep   = final_beat ? keep_expanded : '1;

	////////////////////////////////////////////////////////////
	// Retirement
	////////////////////////////////////////////////////////////
	assign beat_accept = rc_valid && rc_ready;
	assign tag_match   = (rc_tag == expected_tag);

	// A completion carrying a foreign tag frees no window slot
	assign request_retired = beat_accept && rc_last && tag_match;

	always_ff @(posedge CLK) begin
		if (!engine_reset_n) begin
			expected_tag <= '0;
		end else if (request_retired) begin
			expected_tag <= expected_tag + 1'b1;      // Follows rq_tag in order
		end
	end

endmodule

/* source/dma_core.sv */
// Top level of the S2C DMA core, joining the register block, read requester and completion path
`timescale 1ns/100ps
`include "dma_defs.svh"

module dma_core (
	input  logic                        CLK,
	input  logic                        dma_reset_n,
	// Register port
	input  logic                        reg_en,
	input  dma_pkg::reg_offset_e        reg_addr,
	input  logic [`DMA_REG_WIDTH/8-1:0] reg_we,
	input  dma_pkg::reg_data_t          reg_din,
	output dma_pkg::reg_data_t          reg_dout,
	output logic                        reg_ack,
	// Requester stream
	output logic                        rq_valid,
	input  logic                        rq_ready,
	output dma_pkg::host_addr_t         rq_addr,
	output dma_pkg::dw_len_t            rq_len,
	output dma_pkg::tag_t               rq_tag,
	// Completion stream
	input  logic                        rc_valid,
	output logic                        rc_ready,
	input  dma_pkg::data_beat_t         rc_data,
	input  dma_pkg::dw_keep_t           rc_keep,
	input  logic                        rc_last,
	input  dma_pkg::tag_t               rc_tag,
	// S2C user stream
	output logic                        s2c_valid,
	input  logic                        s2c_ready,
	output dma_pkg::data_beat_t         s2c_data,
	output dma_pkg::byte_keep_t         s2c_keep,
	output logic                        s2c_last,
	output logic                        irq,
	output logic                        operation_in_course
);
	import dma_pkg::*;

	host_addr_t              desc_addr;
	reg_data_t               desc_size;
	logic                    start;
	logic                    engine_reset_n;      // Port reset or soft reset
	logic                    done_pulse;
	logic                    all_issued;
	logic [`DMA_TAG_WIDTH:0] outstanding;
	logic                    request_retired;

	dma_registers registers_i (
		.CLK            (CLK),
		.dma_reset_n    (dma_reset_n),
		.reg_en         (reg_en),
		.reg_addr       (reg_addr),
		.reg_we         (reg_we),
		.reg_din        (reg_din),
		.reg_dout       (reg_dout),
		.reg_ack        (reg_ack),
		.running        (operation_in_course),
		.done_pulse     (done_pulse),
		.start          (start),
		.desc_addr      (desc_addr),
		.desc_size      (desc_size),
		.engine_reset_n (engine_reset_n),
		.irq            (irq)
	);

	dma_read_requester requester_i (
		.CLK             (CLK),
		.engine_reset_n  (engine_reset_n),
		.start           (start),
		.desc_addr       (desc_addr),
		.desc_size       (desc_size),
		.rq_ready        (rq_ready),
		.request_retired (request_retired),
		.rq_valid        (rq_valid),
		.rq_addr         (rq_addr),
		.rq_len          (rq_len),
		.rq_tag          (rq_tag),
		.running         (operation_in_course),
		.all_issued      (all_issued),
		.outstanding     (outstanding),
		.done_pulse      (done_pulse)
	);

	dma_completion_stream completion_i (
		.CLK             (CLK),
		.engine_reset_n  (engine_reset_n),
		.rc_valid        (rc_valid),
		.rc_ready        (rc_ready),
		.rc_data         (rc_data),
		.rc_keep         (rc_keep),
		.rc_last         (rc_last),
		.rc_tag          (rc_tag),
		.s2c_valid       (s2c_valid),
		.s2c_ready       (s2c_ready),
		.s2c_data        (s2c_data),
		.s2c_keep        (s2c_keep),
		.s2c_last        (s2c_last),
		.all_issued      (all_issued),
		.outstanding     (outstanding),
		.request_retired (request_retired)
	);

endmodule

/* dv/dma_core_asserts.sv */
// Concurrent checks on the DMA core, bound to the DUT from the testbench file list
`timescale 1ns/100ps
`include "dma_defs.svh"

module dma_core_asserts (
	input logic                    CLK,
	input logic                    dma_reset_n,
	input logic                    engine_reset_n,
	input logic [`DMA_TAG_WIDTH:0] outstanding,
	input logic                    rq_valid,
	input logic                    rq_ready,
	input dma_pkg::host_addr_t     rq_addr,
	input dma_pkg::dw_len_t        rq_len,
	input dma_pkg::tag_t           rq_tag,
	input logic                    s2c_valid,
	input logic                    s2c_ready,
	input dma_pkg::data_beat_t     s2c_data,
	input dma_pkg::byte_keep_t     s2c_keep,
	input logic                    s2c_last,
	input logic                    reg_ack,
	input logic                    irq,
	input logic                    operation_in_course
);

	// Window limit
	a_window: assert property (@(posedge CLK) disable iff (!engine_reset_n)
		outstanding <= `DMA_WINDOW_SIZE)
		else $error("Outstanding requests above the window size");

	a_rq_stable: assert property (@(posedge CLK) disable iff (!engine_reset_n)
		rq_valid && !rq_ready |=> rq_valid && $stable(rq_addr) && $stable(rq_len) &&
		$stable(rq_tag))
		else $error("Request payload changed while stalled");

	a_s2c_stable: assert property (@(posedge CLK) disable iff (!engine_reset_n)
		s2c_valid && !s2c_ready |=> s2c_valid && $stable(s2c_data) && $stable(s2c_keep) &&
		$stable(s2c_last))
		else $error("S2C payload changed while stalled");

	a_reset_low: assert property (@(posedge CLK)
		!dma_reset_n |=> !rq_valid && !reg_ack && !irq && !operation_in_course)
		else $error("Control outputs not low after reset");

endmodule

bind dma_core dma_core_asserts asserts_i (
	.CLK                 (CLK),
	.dma_reset_n         (dma_reset_n),
	.engine_reset_n      (engine_reset_n),
	.outstanding         (outstanding),
	.rq_valid            (rq_valid),
	.rq_ready            (rq_ready),
	.rq_addr             (rq_addr),
	.rq_len              (rq_len),
	.rq_tag              (rq_tag),
	.s2c_valid           (s2c_valid),
	.s2c_ready           (s2c_ready),
	.s2c_data            (s2c_data),
	.s2c_keep            (s2c_keep),
	.s2c_last            (s2c_last),
	.reg_ack             (reg_ack),
	.irq                 (irq),
	.operation_in_course (operation_in_course)
);

/* dv/dma_core_tb.sv */
// Testbench of the DMA core with a host memory model; run through the Makefile in the project root
`timescale 1ns/100ps
`include "dma_defs.svh"

module dma_core_tb;
	import dma_pkg::*;

	localparam int TIMEOUT_CYCLES = 20000;   // Roughly ten times the cycles all tests need

	logic CLK;
	logic dma_reset_n;
	logic reg_en;
	reg_offset_e reg_addr;
	logic [7:0] reg_we;
	reg_data_t reg_din, reg_dout, rd;
	logic reg_ack, rq_valid, rq_ready, rc_valid, rc_ready, rc_last;
	logic s2c_valid, s2c_ready, s2c_last, irq, operation_in_course;
	host_addr_t rq_addr;
	dw_len_t rq_len;
	tag_t rq_tag, rc_tag, next_tag;
	data_beat_t rc_data, s2c_data;
	dw_keep_t rc_keep;
	byte_keep_t s2c_keep;

	// Host model and expected streams
	host_addr_t hq_addr[$], exp_addr_q[$];
	dw_len_t hq_len[$], exp_len_q[$];
	tag_t hq_tag[$], exp_tag_q[$];
	data_beat_t exp_data_q[$];
	byte_keep_t exp_keep_q[$];
	logic exp_last_q[$];
	logic withhold, flush_host, stall_rq, rq_fire, rc_fire, done_check;
	int beat_idx, rem_dw, rq_seen, last_seen, cycle_count, nreq;

	dma_core DUT (.*);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	task automatic stop_run(input string msg);
		$display("%s at %0t ns", msg, $time);
		$display("Test failed");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic value_fail(input string msg);
		$display("FAIL at %0t ns: %s", $time, msg);
		$display("Test failed");
		$fatal(1, "Run stopped at first error");
	endtask

	always @(posedge CLK) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) stop_run("Timeout, the DUT stopped making progress");
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////
	function automatic data_beat_t beat_pattern(input host_addr_t addr);
		data_beat_t d;
		for (int i = 0; i < 8; i++) d[32*i +: 32] = addr[31:0] + 32'(4*i);   // Dword = own address
		return d;
	endfunction

	// Smallest of remaining bytes, max read request and bytes to the 4 KB boundary
	function automatic logic [12:0] request_bytes(input host_addr_t addr, input reg_data_t left);
		logic [12:0] n;
		n = 13'h1000 - {1'b0, addr[11:0]};
		if (n > 13'h1000) n = 13'h1000;
		if (left < 64'(n)) n = left[12:0];
		return n;
	endfunction

	function automatic int expected_requests(input host_addr_t addr, input reg_data_t size,
		input tag_t first_tag);
		host_addr_t a;
		reg_data_t left;
		tag_t t;
		logic [12:0] n;
		int count;
		a = addr;
		left = size;
		t = first_tag;
		count = 0;
		while (left != '0) begin
			n = request_bytes(a, left);
			exp_addr_q.push_back(a);
			exp_len_q.push_back(n[12:2]);
			exp_tag_q.push_back(t);
			a = a + 64'(n);
			left = left - 64'(n);
			t = t + 1'b1;
			count++;
		end
		return count;
	endfunction

	function automatic void expected_beats(input host_addr_t addr, input reg_data_t size);
		host_addr_t a;
		reg_data_t left;
		logic [12:0] n;
		int dws, beats, r;
		logic fin;
		byte_keep_t keep;
		a = addr;
		left = size;
		while (left != '0) begin
			n = request_bytes(a, left);
			dws = int'(n[12:2]);
			beats = (dws + 7) / 8;
			for (int k = 0; k < beats; k++) begin
				fin = (left == 64'(n)) && (k == beats - 1);
				r = dws - 8*k;
				keep = '1;
				if (fin) begin
					for (int i = 0; i < 8; i++) keep[4*i +: 4] = (i < r) ? 4'hF : 4'h0;
				end
				exp_data_q.push_back(beat_pattern(a + 64'(32*k)));
				exp_keep_q.push_back(keep);
				exp_last_q.push_back(fin);
			end
			a = a + 64'(n);
			left = left - 64'(n);
		end
	endfunction

	////////////////////////////////////////////////////////////
	// Compare tasks and process
	////////////////////////////////////////////////////////////
	task automatic check_request(input host_addr_t addr, input dw_len_t len, input tag_t tag);
		host_addr_t ea;
		dw_len_t el;
		tag_t et;
		if (exp_addr_q.size() == 0) stop_run("A read request was issued when none was expected");
		ea = exp_addr_q.pop_front();
		el = exp_len_q.pop_front();
		et = exp_tag_q.pop_front();
		if (addr !== ea || len !== el || tag !== et)
			value_fail($sformatf("request %h/%0d/%0d, expected %h/%0d/%0d",
				addr, len, tag, ea, el, et));
		rq_seen++;
	endtask

	task automatic check_beat(input data_beat_t data, input byte_keep_t keep, input logic last);
		data_beat_t ed;
		byte_keep_t ek;
		logic el;
		if (exp_data_q.size() == 0) stop_run("An S2C beat arrived when none was expected");
		ed = exp_data_q.pop_front();
		ek = exp_keep_q.pop_front();
		el = exp_last_q.pop_front();
		if (data !== ed) value_fail($sformatf("S2C data %h, expected %h", data, ed));
		if (keep !== ek || last !== el)
			value_fail($sformatf("S2C keep %h last %b, expected %h %b", keep, last, ek, el));
		if (last) last_seen++;
	endtask

	task automatic check_reg(input reg_data_t got, input reg_data_t exp, input string what);
		if (got !== exp) value_fail($sformatf("%s is %h, expected %h", what, got, exp));
	endtask

	always @(negedge CLK) begin
		if (done_check) check_reg(64'(operation_in_course), 64'd0, "busy after final beat");
		done_check = 1'b0;
		if (dma_reset_n && rq_valid && rq_ready) check_request(rq_addr, rq_len, rq_tag);
		if (dma_reset_n && s2c_valid && s2c_ready) begin
			done_check = s2c_last;
			check_beat(s2c_data, s2c_keep, s2c_last);
		end
	end

	////////////////////////////////////////////////////////////
	// Host memory model
	////////////////////////////////////////////////////////////
	initial begin
		forever begin
			@(negedge CLK);
			rq_fire = rq_valid && rq_ready;
			rc_fire = rc_valid && rc_ready;
			if (rq_fire) begin
				hq_addr.push_back(rq_addr);
				hq_len.push_back(rq_len);
				hq_tag.push_back(rq_tag);
			end
			@(posedge CLK);
			#10;
			if (flush_host) begin
				hq_addr.delete();
				hq_len.delete();
				hq_tag.delete();
				beat_idx = 0;
				rc_fire = 1'b0;
				flush_host = 1'b0;
			end else if (rc_fire) begin
				beat_idx++;
				if (beat_idx == (int'(hq_len[0]) + 7) / 8) begin
					void'(hq_addr.pop_front());
					void'(hq_len.pop_front());
					void'(hq_tag.pop_front());
					beat_idx = 0;
				end
			end
			rq_ready = (($urandom % 4) != 0) && !stall_rq;
			s2c_ready = ($urandom % 3) != 0;
			if (hq_addr.size() > 0 && (!withhold || (rc_valid && !rc_fire))) begin
				rem_dw = int'(hq_len[0]) - 8*beat_idx;
				rc_valid = 1'b1;
				rc_data = beat_pattern(hq_addr[0] + 64'(32*beat_idx));
				rc_tag = hq_tag[0];
				rc_last = (rem_dw <= 8);
				for (int i = 0; i < 8; i++) rc_keep[i] = (i < rem_dw);
			end else begin
				rc_valid = 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Register access and sequencing
	////////////////////////////////////////////////////////////
	task automatic next_cycle();
		@(posedge CLK);
		#10;
	endtask

	task automatic reg_write(input reg_offset_e a, input reg_data_t d, input logic [7:0] be);
		reg_en = 1'b1;
		reg_addr = a;
		reg_din = d;
		reg_we = be;
		next_cycle();
		reg_en = 1'b0;
		reg_we = '0;
		if (reg_ack !== 1'b1) stop_run("Register write not acknowledged one cycle after reg_en");
	endtask

	task automatic reg_read(input reg_offset_e a, output reg_data_t d);
		reg_en = 1'b1;
		reg_addr = a;
		reg_we = '0;
		next_cycle();
		reg_en = 1'b0;
		if (reg_ack !== 1'b1) stop_run("Register read not acknowledged one cycle after reg_en");
		d = reg_dout;
	endtask

	task automatic start_descriptor(input host_addr_t addr, input reg_data_t size);
		reg_write(ENG_ADDR, addr, 8'hFF);
		reg_write(ENG_SIZE, size, 8'hFF);
		rq_seen = 0;
		last_seen = 0;
		nreq = expected_requests(addr, size, next_tag);
		expected_beats(addr, size);
		next_tag = next_tag + tag_t'(nreq);
		reg_write(ENG_CTRL, 64'h1, 8'h01);
		while (!operation_in_course) next_cycle();
	endtask

	task automatic finish_descriptor();
		while (operation_in_course) next_cycle();
		next_cycle();
		check_reg(64'(exp_addr_q.size() + exp_data_q.size()), 64'd0, "items still expected");
		check_reg(64'(last_seen), 64'd1, "s2c_last count");
	endtask

	initial begin
		void'($urandom(6972));
		dma_reset_n = 1'b0;
		reg_en = 1'b0;
		reg_addr = ENG_CTRL;
		reg_we = '0;
		reg_din = '0;
		rq_ready = 1'b0;
		rc_valid = 1'b0;
		rc_data = '0;
		rc_keep = '0;
		rc_last = 1'b0;
		rc_tag = '0;
		s2c_ready = 1'b0;
		withhold = 1'b0;
		flush_host = 1'b0;
		stall_rq = 1'b0;
		done_check = 1'b0;
		next_tag = '0;
		beat_idx = 0;
		cycle_count = 0;
		repeat (8) @(posedge CLK);
		#10 dma_reset_n = 1'b1;
		check_reg(64'({irq, operation_in_course, rq_valid, reg_ack}), 64'd0, "outputs after reset");

		// Register readback with byte enables
		reg_write(ENG_ADDR, 64'h1111_2222_3333_4444, 8'hFF);
		reg_write(ENG_ADDR, 64'hAAAA_AAAA_AAAA_AAAA, 8'h0F);
		reg_read(ENG_ADDR, rd);
		check_reg(rd, 64'h1111_2222_AAAA_AAAA, "ENG_ADDR");
		reg_write(ENG_SIZE, 64'h0000_0000_0001_2340, 8'hFF);
		reg_read(ENG_SIZE, rd);
		check_reg(rd, 64'h0000_0000_0001_2340, "ENG_SIZE");
		reg_read(GLOBAL_CTRL, rd);
		check_reg(rd, 64'h29, "GLOBAL_CTRL codes");

		// Splitting across a 4 KB boundary, irq enabled
		reg_write(GLOBAL_CTRL, 64'h40, 8'h01);
		start_descriptor(64'h1C00, 64'd10000);
		finish_descriptor();
		check_reg(64'(irq), 64'd1, "irq");
		reg_read(ENG_CTRL, rd);
		check_reg(rd, 64'h82, "ENG_CTRL after done");
		reg_write(ENG_CTRL, 64'h80, 8'h01);
		reg_read(ENG_CTRL, rd);
		check_reg(rd, 64'h0, "ENG_CTRL after clear");
		check_reg(64'(irq), 64'd0, "irq after clear");

		// Window with completions withheld, irq disabled
		reg_write(GLOBAL_CTRL, 64'h00, 8'h01);
		withhold = 1'b1;
		start_descriptor(64'h0, 64'd20000);
		while (rq_seen < 4) next_cycle();
		repeat (40) next_cycle();
		check_reg(64'(rq_seen), 64'd4, "requests accepted with completions withheld");
		withhold = 1'b0;
		finish_descriptor();
		check_reg(64'(irq), 64'd0, "irq while disabled");
		reg_read(ENG_CTRL, rd);
		check_reg(rd, 64'h82, "ENG_CTRL after done");
		reg_write(GLOBAL_CTRL, 64'h40, 8'h01);
		check_reg(64'(irq), 64'd1, "irq once enabled");
		reg_write(ENG_CTRL, 64'h80, 8'h01);
		check_reg(64'(irq), 64'd0, "irq after clear");

		// Soft reset in the middle of a descriptor, third request held on the bus
		withhold = 1'b1;
		start_descriptor(64'h3000, 64'd40000);
		while (rq_seen < 2) next_cycle();
		stall_rq = 1'b1;
		while (!rq_valid) next_cycle();
		reg_write(GLOBAL_CTRL, 64'hC0, 8'h01);
		next_cycle();
		check_reg(64'({operation_in_course, rq_valid}), 64'd0, "busy and rq_valid after soft reset");
		flush_host = 1'b1;
		exp_addr_q.delete();
		exp_len_q.delete();
		exp_tag_q.delete();
		exp_data_q.delete();
		exp_keep_q.delete();
		exp_last_q.delete();
		next_tag = '0;
		repeat (2) next_cycle();
		withhold = 1'b0;
		stall_rq = 1'b0;
		start_descriptor(64'h5_0F80, 64'd6000);
		finish_descriptor();
		check_reg(64'(irq), 64'd1, "irq after restart");

		$display("Test passed");
		$finish;
	end

endmodule

/* pcie_dma_lite.f */
+incdir+source
source/dma_pkg.sv
source/dma_registers.sv
source/dma_read_requester.sv
source/dma_completion_stream.sv
source/dma_core.sv
dv/dma_core_asserts.sv
dv/dma_core_tb.sv

/* Makefile */
# Verilator build, run, lint and clean for the DMA core

VERILATOR ?= verilator
TOP       := dma_core_tb
RTL_TOP   := dma_core
FILELIST  := pcie_dma_lite.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
